/* video_gen.f */
+incdir+common
common/video_pkg.sv
common/video_timing_if.sv
common/playfield_cfg_if.sv
hdl/video_regs.sv
video_sync/video_sync.sv
playfield/bitmap_fetch.sv
hdl/video_out.sv
hdl/video_gen.sv
tests/video_gen_tb.sv

/* tests/video_gen_tb.sv */
// testbench for the raster video generator
// random register setup from a fixed seed, a video memory model and
// a reference model that predicts every displayed pixel and the frame shape

`include "video_gen_config.svh"

module video_gen_tb;

import video_pkg::*;

localparam int DLY       = 10;                          // drive delay after the rising edge
localparam int FRAME_CYC = `TOTAL_WIDTH * `TOTAL_HEIGHT;

logic       clk;
logic       reset_i;
logic       reg_wr_en_i;
xr_reg_e    reg_num_i;
word_t      reg_data_i;
word_t      reg_data_o;
logic [3:0] intr_status_i;
logic [3:0] intr_signal_o;
logic       vram_sel_o;
addr_t      vram_addr_o;
word_t      vram_data_i;
color_t     color_index_o;
logic       hsync_o;
logic       vsync_o;
logic       dv_de_o;

color_t     m_border;                                   // reference register state
word_t      m_left;
word_t      m_right;
color_t     m_colorbase;
logic       m_blank;
addr_t      m_start;
word_t      m_line_len;
logic       mem_pending;                                // request seen last cycle
addr_t      mem_addr;

video_gen dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .intr_status_i  (intr_status_i),
    .intr_signal_o  (intr_signal_o),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_i    (vram_data_i),
    .color_index_o  (color_index_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

initial clk = 1'b0;
always #50 clk = ~clk;

// memory contents depend on every address bit
function automatic word_t scramble(input addr_t a);
    return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
endfunction

// video memory model answers one cycle after the request
always @(posedge clk) begin
    #DLY;
    vram_data_i = mem_pending ? scramble(mem_addr) : 16'h0000;
    mem_pending = vram_sel_o;
    mem_addr    = vram_addr_o;
end

function automatic color_t predict_pixel(input int line, input int col);
    addr_t a;
    word_t w;
    if (m_blank || col < int'(m_left) || col >= int'(m_right))
        return m_border;
    a = m_start + addr_t'(line * int'(m_line_len)) + addr_t'(col / 2);
    w = scramble(a);
    return ((col % 2 == 0) ? w[15:8] : w[7:0]) ^ m_colorbase;    // high byte first
endfunction

// address of the n-th word read in a frame
function automatic addr_t predict_addr(input int n);
    int pairs;
    pairs = `VIS_WIDTH / 2;
    return m_start + addr_t'((n / pairs) * int'(m_line_len)) + addr_t'(n % pairs);
endfunction

function automatic word_t expected_read(input xr_reg_e num);
    case (num)
        VID_CTRL:     return {m_border, 4'h0, intr_status_i};
        VID_LEFT:     return m_left;
        VID_RIGHT:    return m_right;
        VID_HSIZE:    return word_t'(`VIS_WIDTH);
        VID_VSIZE:    return word_t'(`VIS_HEIGHT);
        PA_GFX_CTRL:  return {m_colorbase, m_blank, 7'h00};
        PA_DISP_ADDR: return m_start;
        PA_LINE_LEN:  return m_line_len;
        default:      return 16'h0000;
    endcase
endfunction

task automatic model_write(input xr_reg_e num, input word_t data);
    case (num)
        VID_CTRL:     m_border = data[15:8];
        VID_LEFT:     m_left = data;
        VID_RIGHT:    m_right = data;
        PA_GFX_CTRL: begin
            m_colorbase = data[15:8];
            m_blank     = data[7];
        end
        PA_DISP_ADDR: m_start = data;
        PA_LINE_LEN:  m_line_len = data;
        default: begin
        end
    endcase
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end
endtask

task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic step();
    @(posedge clk);
    #DLY;                                               // drive and sample point
endtask

task automatic write_reg(input xr_reg_e num, input word_t data);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    model_write(num, data);
    step();
    reg_wr_en_i = 1'b0;
endtask

task automatic read_reg(input xr_reg_e num, output word_t data);
    reg_num_i = num;
    step();
    data = reg_data_o;                                  // one cycle of read latency
endtask

task automatic check_reg(input xr_reg_e num);
    word_t data;
    read_reg(num, data);
    check_value($sformatf("reg_data_o %s", num.name()), data, expected_read(num));
endtask

task automatic write_and_check(input xr_reg_e num, input word_t data);
    write_reg(num, data);
    check_reg(num);
endtask

// leaves at the first cycle with vsync_o active
task automatic wait_vsync_start();
    int guard;
    guard = 0;
    while (vsync_o == `V_SYNC_POL) begin
        step();
        guard++;
        if (guard > FRAME_CYC)
            timeout_fail("vsync_o did not go inactive");
    end
    guard = 0;
    while (vsync_o != `V_SYNC_POL) begin
        step();
        guard++;
        if (guard > 2 * FRAME_CYC)
            timeout_fail("no vsync_o pulse was seen");
    end
endtask

// one frame from vsync start to the next vsync start
task automatic check_frame();
    int   guard;
    int   vs_len;
    int   hs_len;
    int   hs_runs;
    int   de_len;
    int   runs;
    int   irqs;
    int   reads;
    logic vs_prev;
    guard   = 0;
    vs_len  = 0;
    hs_len  = 0;
    hs_runs = 0;
    de_len  = 0;
    runs    = 0;
    irqs    = 0;
    reads   = 0;
    wait_vsync_start();
    do begin
        if (vsync_o == `V_SYNC_POL)
            vs_len++;
        if (hsync_o == `H_SYNC_POL) begin
            hs_len++;
        end else if (hs_len != 0) begin
            check_value("hsync_o active cycles", hs_len, `H_SYNC_PULSE);
            hs_runs++;
            hs_len = 0;
        end
        if (dv_de_o) begin
            if (de_len == 0)
                runs++;                                 // line index since vsync
            check_value("color_index_o", color_index_o, predict_pixel(runs - 1, de_len));
            de_len++;
        end else begin
            if (de_len != 0)
                check_value("dv_de_o run length", de_len, `VIS_WIDTH);
            de_len = 0;
            check_value("color_index_o outside de", color_index_o, 0);
        end
        if (vram_sel_o) begin
            check_value("vram_addr_o", vram_addr_o, predict_addr(reads));
            reads++;
        end
        check_value("intr_signal_o[2:0]", intr_signal_o[2:0], 0);
        if (intr_signal_o[3]) begin
            irqs++;
            check_value("dv_de_o runs before intr_signal_o[3]", runs, `VIS_HEIGHT);
        end
        vs_prev = (vsync_o == `V_SYNC_POL);
        step();
        guard++;
        if (guard > 2 * FRAME_CYC)
            timeout_fail("frame did not end with a new vsync_o pulse");
    end while (!((vsync_o == `V_SYNC_POL) && !vs_prev));
    check_value("vsync_o active cycles", vs_len, `V_SYNC_PULSE * `TOTAL_WIDTH);
    check_value("hsync_o pulses per frame", hs_runs, `TOTAL_HEIGHT);
    check_value("dv_de_o runs per frame", runs, `VIS_HEIGHT);
    check_value("vram_sel_o reads per frame", reads, `VIS_HEIGHT * `VIS_WIDTH / 2);
    check_value("intr_signal_o[3] pulses per frame", irqs, 1);
endtask

initial begin
    int    i;
    word_t data;
    intr_status_i = 4'($urandom(32'h7139));
    reset_i       = 1'b1;
    reg_wr_en_i   = 1'b0;
    reg_num_i     = VID_CTRL;
    reg_data_i    = 16'h0000;
    vram_data_i   = 16'h0000;
    mem_pending   = 1'b0;
    mem_addr      = 16'h0000;
    m_border      = `BORDER_RESET;
    m_left        = 16'h0000;
    m_right       = word_t'(`VIS_WIDTH);
    m_colorbase   = 8'h00;
    m_blank       = 1'b1;
    m_start       = 16'h0000;
    m_line_len    = word_t'(`LINE_LEN_RESET);
    repeat (2) @(posedge clk);
    #DLY;
    reset_i = 1'b0;

    // reset values and one blanked frame
    check_reg(VID_CTRL);
    check_reg(VID_LEFT);
    check_reg(VID_RIGHT);
    check_reg(VID_HSIZE);
    check_reg(VID_VSIZE);
    check_reg(PA_GFX_CTRL);
    check_reg(PA_DISP_ADDR);
    check_reg(PA_LINE_LEN);
    check_frame();

    for (i = 0; i < 4; i++) begin
        write_and_check(VID_LEFT, 16'($urandom));
        write_and_check(VID_RIGHT, 16'($urandom));
        write_and_check(PA_GFX_CTRL, 16'($urandom));
        write_and_check(PA_DISP_ADDR, 16'($urandom));
        write_and_check(PA_LINE_LEN, 16'($urandom));
        write_and_check(VID_CTRL, 16'($urandom));
    end
    // one line and one column apart, so every line gets sampled
    for (i = 0; i < 16; i++) begin
        read_reg(SCANLINE, data);
        check_value("reg_data_o SCANLINE line below total", data[13:0] < `TOTAL_HEIGHT, 1);
        check_value("reg_data_o SCANLINE[15]", data[15], data[13:0] >= `VIS_HEIGHT);
        repeat (48) step();
    end

    // software interrupts well away from vertical blank
    wait_vsync_start();
    for (i = 0; i < 6; i++) begin
        data = 16'($urandom);
        write_reg(VID_CTRL, data);
        check_value("intr_signal_o", intr_signal_o, data[3:0]);
        step();
        check_value("intr_signal_o after pulse", intr_signal_o, 0);
    end

    for (i = 0; i < 4; i++) begin
        write_reg(VID_CTRL, {8'($urandom), 8'h00});
        write_reg(VID_LEFT, 16'($urandom_range(20)));
        write_reg(VID_RIGHT, 16'($urandom_range(40, 8)));
        write_reg(PA_DISP_ADDR, 16'($urandom));
        write_reg(PA_LINE_LEN, 16'($urandom));
        write_reg(PA_GFX_CTRL, {8'($urandom), (i == 3), 7'h00});    // last frame blanked
        check_frame();
    end

    $display("Simulation finished: PASS");
    $finish;
end

endmodule

/* hdl/video_gen.sv */
// raster video generator top level
// host register file, sync generator, bitmap playfield and output stage
// joined by the timing and playfield configuration interfaces

module video_gen
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           reg_wr_en_i,        // host register write strobe
    input  wire xr_reg_e        reg_num_i,
    input  wire word_t          reg_data_i,
    output      word_t          reg_data_o,
    input  wire logic [3:0]     intr_status_i,
    output      logic [3:0]     intr_signal_o,
    output      logic           vram_sel_o,         // video memory read
    output      addr_t          vram_addr_o,
    input  wire word_t          vram_data_i,
    output      color_t         color_index_o,      // pixel palette index
    output      logic           hsync_o,
    output      logic           vsync_o,
    output      logic           dv_de_o
);

video_timing_if     timing_if();
playfield_cfg_if    cfg_if();
color_t             pix;                            // playfield pixel into output stage

video_regs u_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .intr_status_i  (intr_status_i),
    .intr_signal_o  (intr_signal_o),
    .timing         (timing_if),
    .cfg            (cfg_if)
);

video_sync u_sync (
    .clk            (clk),
    .reset_i        (reset_i),
    .timing         (timing_if)
);

bitmap_fetch u_fetch (
    .clk            (clk),
    .reset_i        (reset_i),
    .timing         (timing_if),
    .cfg            (cfg_if),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_i    (vram_data_i),
    .pix_o          (pix)
);

video_out u_out (
    .clk            (clk),
    .reset_i        (reset_i),
    .timing         (timing_if),
    .pix_i          (pix),
    .color_index_o  (color_index_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

endmodule

/* hdl/video_out.sv */
// video output stage
// delays sync and display enable to line up with the pixel pipeline,
// applies sync polarity and blanks the colour outside display enable

`include "video_gen_config.svh"

module video_out
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    video_timing_if.reader      timing,
    input  wire color_t         pix_i,
    output      color_t         color_index_o,
    output      logic           hsync_o,
    output      logic           vsync_o,
    output      logic           dv_de_o
);

logic [`FETCH_LAT-1:0][2:0] ctl_dly;                // {hsync, vsync, de}, stage 0 newest
logic       hsync_d;
logic       vsync_d;
logic       de_d;

assign {hsync_d, vsync_d, de_d} = ctl_dly[`FETCH_LAT-1];

always_ff @(posedge clk) begin
    if (reset_i) begin
        ctl_dly         <= '0;
        hsync_o         <= ~`H_SYNC_POL;            // inactive level
        vsync_o         <= ~`V_SYNC_POL;
        dv_de_o         <= 1'b0;
        color_index_o   <= '0;
    end else begin
        ctl_dly         <= {ctl_dly[`FETCH_LAT-2:0],
                            {timing.hsync_next, timing.vsync_next, timing.de_next}};
        hsync_o         <= hsync_d ? `H_SYNC_POL : ~`H_SYNC_POL;
        vsync_o         <= vsync_d ? `V_SYNC_POL : ~`V_SYNC_POL;
        dv_de_o         <= de_d;
        color_index_o   <= de_d ? pix_i : 8'h00;    // black outside display
    end
end

endmodule

/* playfield/bitmap_fetch.sv */
// bitmap playfield fetch
// reads one vram word per pixel pair while the previous pair shifts out,
// unpacks two 8-bit pixels high byte first and applies colour base,
// window and border; a pixel leaves FETCH_LAT cycles after its position

`include "video_gen_config.svh"

module bitmap_fetch
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    video_timing_if.reader      timing,
    playfield_cfg_if.reader     cfg,
    output      logic           vram_sel_o,         // read request
    output      addr_t          vram_addr_o,
    input  wire word_t          vram_data_i,        // valid the cycle after a request
    output      color_t         pix_o
);

addr_t      line_addr;                              // first word of the current line
hres_t      col;                                    // visible column at the counters
hres_t      fetch_col;                              // column of the next cycle
logic       fetch_go;
logic       data_valid;                             // vram_data_i holds a requested word
word_t      pix_shift;
hres_t      col_d1;
hres_t      col_d2;                                 // column of the pixel being formed
logic       in_window;

assign col       = timing.h_count - hres_t'(`OFFSCREEN_WIDTH);
assign fetch_col = col + 1'b1;                      // wraps high while offscreen
assign fetch_go  = (timing.v_state == VISIBLE) && !fetch_col[0] &&
                   (fetch_col < hres_t'(`VIS_WIDTH));

always_ff @(posedge clk) begin
    if (timing.frame_start) begin
        line_addr <= cfg.start_addr;
    end else if (timing.line_end && timing.v_state == VISIBLE) begin
        line_addr <= line_addr + cfg.line_len;      // step to next line
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o <= 1'b0;
        data_valid <= 1'b0;
    end else begin
        vram_sel_o <= fetch_go;                     // even columns only
        data_valid <= vram_sel_o;
    end
end

assign in_window = (word_t'(col_d2) >= cfg.vid_left) && (word_t'(col_d2) < cfg.vid_right);

always_ff @(posedge clk) begin
    vram_addr_o <= line_addr + addr_t'(fetch_col >> 1);
    if (data_valid) begin
        pix_shift <= vram_data_i;                   // new pair, high byte first
    end else begin
        pix_shift <= {pix_shift[7:0], 8'h00};
    end
    col_d1 <= col;
    col_d2 <= col_d1;
    if (cfg.blank || !in_window) begin
        pix_o <= cfg.border_color;
    end else begin
        pix_o <= pix_shift[15:8] ^ cfg.colorbase;
    end
end

// no vram traffic outside the visible lines
a_sel_visible_line: assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_o |-> timing.v_state == VISIBLE);

endmodule

/* video_sync/video_sync.sv */
// raster sync generator
// horizontal and vertical pre-sync/sync/post-sync/visible state machines
// with their counters, plus the sync, enable and frame event conditions

`include "video_gen_config.svh"

module video_sync
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    video_timing_if.driver      timing
);

sync_state_e    h_state;
sync_state_e    h_state_next;
sync_state_e    v_state;
sync_state_e    v_state_next;
hres_t          h_count;
hres_t          h_count_next;
hres_t          h_limit;                            // last column of the current h state
vres_t          v_count;
vres_t          v_count_next;
vres_t          v_limit;                            // last line of the current v state
logic           line_end;
logic           frame_start;
logic           vblank_start;

// offscreen columns first on each line
always_comb begin
    case (h_state)
        PRE_SYNC:   h_limit = hres_t'(`H_FRONT_PORCH - 1);
        SYNC:       h_limit = hres_t'(`H_FRONT_PORCH + `H_SYNC_PULSE - 1);
        POST_SYNC:  h_limit = hres_t'(`OFFSCREEN_WIDTH - 1);
        default:    h_limit = hres_t'(`TOTAL_WIDTH - 1);
    endcase
end

// visible lines first in each frame
always_comb begin
    case (v_state)
        PRE_SYNC:   v_limit = vres_t'(`VIS_HEIGHT + `V_FRONT_PORCH - 1);
        SYNC:       v_limit = vres_t'(`VIS_HEIGHT + `V_FRONT_PORCH + `V_SYNC_PULSE - 1);
        POST_SYNC:  v_limit = vres_t'(`TOTAL_HEIGHT - 1);
        default:    v_limit = vres_t'(`VIS_HEIGHT - 1);
    endcase
end

assign line_end     = (h_state == VISIBLE) && (h_count == h_limit);
assign frame_start  = line_end && (v_state == POST_SYNC) && (v_count == v_limit);
assign vblank_start = line_end && (v_state == VISIBLE) && (v_count == v_limit);

assign h_state_next = (h_count == h_limit) ? sync_state_e'(h_state + 2'd1) : h_state;
assign v_state_next = (line_end && v_count == v_limit) ? sync_state_e'(v_state + 2'd1) : v_state;
assign h_count_next = line_end ? '0 : h_count + 1'b1;
assign v_count_next = frame_start ? '0 : (line_end ? v_count + 1'b1 : v_count);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_state <= PRE_SYNC;
        h_count <= '0;
        v_state <= POST_SYNC;                       // start on the last line of a frame
        v_count <= vres_t'(`TOTAL_HEIGHT - 1);
    end else begin
        h_state <= h_state_next;
        h_count <= h_count_next;
        v_state <= v_state_next;
        v_count <= v_count_next;
    end
end

assign timing.h_count       = h_count;
assign timing.v_count       = v_count;
assign timing.h_state       = h_state;
assign timing.v_state       = v_state;
assign timing.hsync_next    = (h_state == SYNC);
assign timing.vsync_next    = (v_state == SYNC);
assign timing.de_next       = (h_state == VISIBLE) && (v_state == VISIBLE);
assign timing.line_end      = line_end;
assign timing.frame_start   = frame_start;
assign timing.vblank_start  = vblank_start;

a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
    h_count < hres_t'(`TOTAL_WIDTH));

a_line_end_pulse: assert property (@(posedge clk) disable iff (reset_i)
    line_end |=> !line_end);

endmodule

/* hdl/video_regs.sv */
// video register file
// host writes with a one-cycle strobe, read data follows one cycle later
// feeds the playfield configuration and pulses the interrupt lines

`include "video_gen_config.svh"

module video_regs
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           reg_wr_en_i,        // write strobe
    input  wire xr_reg_e        reg_num_i,          // register for write and read
    input  wire word_t          reg_data_i,
    output      word_t          reg_data_o,         // read data, one cycle late
    input  wire logic [3:0]     intr_status_i,      // pending status from host side
    output      logic [3:0]     intr_signal_o,      // one-cycle pulses
    video_timing_if.reader      timing,
    playfield_cfg_if.driver     cfg
);

color_t     border_color;
word_t      vid_left;
word_t      vid_right;
color_t     colorbase;
logic       blank;
addr_t      start_addr;
word_t      line_len;
word_t      rd_word;

assign cfg.border_color = border_color;
assign cfg.vid_left     = vid_left;
assign cfg.vid_right    = vid_right;
assign cfg.colorbase    = colorbase;
assign cfg.blank        = blank;
assign cfg.start_addr   = start_addr;
assign cfg.line_len     = line_len;

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_signal_o   <= 4'b0;
        border_color    <= `BORDER_RESET;           // grey border shows the block is alive
        vid_left        <= '0;
        vid_right       <= word_t'(`VIS_WIDTH);
        colorbase       <= '0;
        blank           <= 1'b1;                    // playfield off until set up
        start_addr      <= '0;
        line_len        <= word_t'(`LINE_LEN_RESET);
    end else begin
        intr_signal_o   <= 4'b0;
        if (reg_wr_en_i) begin
            case (reg_num_i)
                VID_CTRL: begin
                    border_color    <= reg_data_i[15:8];
                    intr_signal_o   <= reg_data_i[3:0];     // software interrupts
                end
                VID_LEFT:       vid_left    <= reg_data_i;
                VID_RIGHT:      vid_right   <= reg_data_i;
                PA_GFX_CTRL: begin
                    colorbase       <= reg_data_i[15:8];
                    blank           <= reg_data_i[7];
                end
                PA_DISP_ADDR:   start_addr  <= reg_data_i;
                PA_LINE_LEN:    line_len    <= reg_data_i;
                default: begin
                end
            endcase
        end
        if (timing.vblank_start) begin
            intr_signal_o[3] <= 1'b1;                       // vertical blank interrupt
        end
    end
end

// read-back selection
always_comb begin
    case (reg_num_i)
        VID_CTRL:       rd_word = {border_color, 4'b0, intr_status_i};
        VID_LEFT:       rd_word = vid_left;
        VID_RIGHT:      rd_word = vid_right;
        SCANLINE:       rd_word = {timing.v_state != VISIBLE, timing.h_state != VISIBLE,
                                   14'(timing.v_count)};
        VID_HSIZE:      rd_word = word_t'(`VIS_WIDTH);
        VID_VSIZE:      rd_word = word_t'(`VIS_HEIGHT);
        PA_GFX_CTRL:    rd_word = {colorbase, blank, 7'b0};
        PA_DISP_ADDR:   rd_word = start_addr;
        PA_LINE_LEN:    rd_word = line_len;
        default:        rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_word;
end

// the host only writes registers that exist
a_wr_reg_known: assert property (@(posedge clk) disable iff (reset_i)
    reg_wr_en_i |-> reg_num_i inside {VID_CTRL, VID_LEFT, VID_RIGHT, SCANLINE, VID_HSIZE,
                                      VID_VSIZE, PA_GFX_CTRL, PA_DISP_ADDR, PA_LINE_LEN});

endmodule

/* common/playfield_cfg_if.sv */
// playfield configuration levels
// written by the register file, used by the bitmap fetch unit

interface playfield_cfg_if
    import video_pkg::*;
();

logic           blank;              // show border only
color_t         colorbase;          // xor'd into every pixel
addr_t          start_addr;         // first word of the frame
word_t          line_len;           // words per line
word_t          vid_left;           // window start column, included
word_t          vid_right;          // window end column, excluded
color_t         border_color;

modport driver (output blank, colorbase, start_addr, line_len, vid_left, vid_right,
                border_color);

modport reader (input blank, colorbase, start_addr, line_len, vid_left, vid_right,
                border_color);

endinterface

/* common/video_timing_if.sv */
// raster position and frame events
// driven by the sync generator, read by registers, playfield and output stage

interface video_timing_if
    import video_pkg::*;
();

hres_t          h_count;            // current column
vres_t          v_count;            // current line
sync_state_e    h_state;
sync_state_e    v_state;
logic           hsync_next;         // conditions for the current position
logic           vsync_next;
logic           de_next;
logic           line_end;           // last pixel of every line
logic           frame_start;        // last pixel of the frame
logic           vblank_start;       // last visible pixel of the frame

modport driver (output h_count, v_count, h_state, v_state, hsync_next, vsync_next,
                de_next, line_end, frame_start, vblank_start);

modport reader (input h_count, v_count, h_state, v_state, hsync_next, vsync_next,
                de_next, line_end, frame_start, vblank_start);

endinterface

/* common/video_pkg.sv */
// shared types of the raster video generator
// data and address words, pixel index, raster counters,
// sync states and the host register numbers

`include "video_gen_config.svh"

package video_pkg;

localparam int H_BITS = $clog2(`TOTAL_WIDTH);   // enough for the whole line
localparam int V_BITS = $clog2(`TOTAL_HEIGHT);

typedef logic [15:0] word_t;                    // register or vram data word
typedef logic [15:0] addr_t;                    // vram word address
typedef logic [7:0]  color_t;                   // palette index
typedef logic [H_BITS-1:0] hres_t;              // horizontal counter
typedef logic [V_BITS-1:0] vres_t;              // vertical counter

// one machine each for horizontal and vertical, stepping in this order
typedef enum logic [1:0] {
    PRE_SYNC  = 2'b00,
    SYNC      = 2'b01,
    POST_SYNC = 2'b10,
    VISIBLE   = 2'b11
} sync_state_e;

// host register numbers, bit 4 splits video and playfield groups
typedef enum logic [4:0] {
    VID_CTRL     = 5'h00,
    VID_LEFT     = 5'h06,
    VID_RIGHT    = 5'h07,
    SCANLINE     = 5'h08,
    VID_HSIZE    = 5'h0A,
    VID_VSIZE    = 5'h0B,
    PA_GFX_CTRL  = 5'h10,
    PA_DISP_ADDR = 5'h12,
    PA_LINE_LEN  = 5'h13
} xr_reg_e;

endpackage

/* common/video_gen_config.svh */
// raster generator build constants
// timing is kept tiny so that a whole frame simulates quickly
// also holds the sync polarities, the pixel pipeline depth and register reset values

`ifndef VIDEO_GEN_CONFIG_SVH
`define VIDEO_GEN_CONFIG_SVH

// horizontal timing in pixels, offscreen part comes first on a line
`define VIS_WIDTH       32
`define H_FRONT_PORCH   4
`define H_SYNC_PULSE    4
`define H_BACK_PORCH    8
`define OFFSCREEN_WIDTH (`H_FRONT_PORCH + `H_SYNC_PULSE + `H_BACK_PORCH)
`define TOTAL_WIDTH     (`OFFSCREEN_WIDTH + `VIS_WIDTH)

// vertical timing in lines, visible lines come first in a frame
`define VIS_HEIGHT      8
`define V_FRONT_PORCH   2
`define V_SYNC_PULSE    2
`define V_BACK_PORCH    3
`define TOTAL_HEIGHT    (`VIS_HEIGHT + `V_FRONT_PORCH + `V_SYNC_PULSE + `V_BACK_PORCH)

// sync polarity, 0 is active low
`define H_SYNC_POL      (1'b0)
`define V_SYNC_POL      (1'b0)

// cycles from counter position to playfield pixel
`define FETCH_LAT       3

// register reset values
`define BORDER_RESET    (8'h08)
`define LINE_LEN_RESET  (`VIS_WIDTH / 2)

`endif
